// File: source/daq2_regs_pkg.sv
// local register map and gpio bit layout, used by the host decoder, the gpio block and the top level
`default_nettype none

package daq2_regs_pkg;

  // ******************************
  // host side
  // ******************************

  localparam int CMD_DATA_W = 16;
  localparam int LOC_ADDR_W = 2;

  // local register addresses
  localparam logic [LOC_ADDR_W-1:0] ADDR_BD_OUT    = LOC_ADDR_W'(0);
  localparam logic [LOC_ADDR_W-1:0] ADDR_CTRL_OUT  = LOC_ADDR_W'(1);
  localparam logic [LOC_ADDR_W-1:0] ADDR_STATUS_IN = LOC_ADDR_W'(2);
  localparam logic [LOC_ADDR_W-1:0] ADDR_BD_IN     = LOC_ADDR_W'(3);

  // ******************************
  // board and converter gpio
  // ******************************

  localparam int BD_OUT_W   = 16;
  localparam int BD_IN_W    = 11;
  localparam int CTRL_OUT_W = 4;

  // converter control bits
  localparam int CTRL_DAC_RESET = 0;
  localparam int CTRL_DAC_TXEN  = 1;
  localparam int CTRL_ADC_PD    = 2;
  localparam int CTRL_CLKD_SYNC = 3;

  // status bits, clock chip status is two wide
  localparam int STATUS_W     = 6;
  localparam int STAT_CLKD    = 0;
  localparam int STAT_CLKD_W  = 2;
  localparam int STAT_DAC_IRQ = 2;
  localparam int STAT_ADC_FDA = 3;
  localparam int STAT_ADC_FDB = 4;
  localparam int STAT_TRIG    = 5;

  localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire

// File: source/daq2_spi_pkg.sv
// spi frame layout, sclk divider and chip-select codes, used by the spi blocks and the top level
`default_nettype none

package daq2_spi_pkg;

  // frame is one instruction word followed by one data byte
  localparam int INSTR_W    = 16;
  localparam int SPI_ADDR_W = 15;
  localparam int SPI_DATA_W = 8;
  localparam int FRAME_W    = INSTR_W + SPI_DATA_W;

  // sys_clk cycles per sclk half period
  localparam int SPI_DIV = 4;

  // ******************************
  // devices on the shared bus
  // ******************************

  localparam int N_DEV   = 3;
  localparam int DEV_W   = 2;
  localparam int DEV_CLK = 0;
  localparam int DEV_DAC = 1;
  localparam int DEV_ADC = 2;

  // counter widths and terminal counts
  localparam int DIV_CNT_W = $clog2(SPI_DIV);
  localparam int BIT_CNT_W = $clog2(FRAME_W + 1);

  localparam logic [DIV_CNT_W-1:0] DIV_LAST   = DIV_CNT_W'(SPI_DIV - 1);
  localparam logic [BIT_CNT_W-1:0] FRAME_CNT  = BIT_CNT_W'(FRAME_W);
  localparam logic [BIT_CNT_W-1:0] INSTR_LAST = BIT_CNT_W'(INSTR_W - 1);

endpackage

`default_nettype wire

// File: source/daq2_spi_if.sv
// one spi transaction request and its result, passed from the command decoder to the spi engine
`timescale 1ns/1ns
`default_nettype none

interface daq2_spi_if;

  // request, held by ctrl until done
  logic                               start;
  logic [daq2_spi_pkg::DEV_W-1:0]      dev;
  logic                               rd;
  logic [daq2_spi_pkg::SPI_ADDR_W-1:0] addr;
  logic [daq2_spi_pkg::SPI_DATA_W-1:0] wdata;

  // result, rdata valid with done
  logic [daq2_spi_pkg::SPI_DATA_W-1:0] rdata;
  logic                               done;

  modport ctrl (
    output start, dev, rd, addr, wdata,
    input  rdata, done
  );

  modport engine (
    input  start, dev, rd, addr, wdata,
    output rdata, done
  );

endinterface

`default_nettype wire

// File: source/daq2_ctrl.sv
// host command decoder, answers local register accesses directly and hands spi commands to the engine
`timescale 1ns/1ns
`default_nettype none

module daq2_ctrl (
  input  logic                                 sys_clk,
  input  logic                                 rst_i,

  // host command
  input  logic                                 cmd_valid_i,
  input  logic                                 cmd_spi_i,
  input  logic                                 cmd_write_i,
  input  logic [daq2_spi_pkg::DEV_W-1:0]        cmd_dev_i,
  input  logic [daq2_spi_pkg::SPI_ADDR_W-1:0]   cmd_addr_i,
  input  logic [daq2_regs_pkg::CMD_DATA_W-1:0]  cmd_wdata_i,

  // host response
  output logic                                 rsp_valid_o,
  output logic [daq2_regs_pkg::CMD_DATA_W-1:0]  rsp_rdata_o,
  output logic                                 busy_o,

  // local registers
  output logic                                 gpio_wr_o,
  output logic [daq2_regs_pkg::LOC_ADDR_W-1:0]  gpio_addr_o,
  output logic [daq2_regs_pkg::CMD_DATA_W-1:0]  gpio_wdata_o,
  input  logic [daq2_regs_pkg::CMD_DATA_W-1:0]  gpio_rdata_i,

  // spi engine
  daq2_spi_if.ctrl                             spi
);

  logic busy_q;
  logic rsp_valid_q;
  logic start_q;
  logic accept;
  logic local_acc;
  logic spi_acc;

  // commands are dropped while an spi transaction is open
  assign accept    = cmd_valid_i & ~busy_q;
  assign local_acc = accept & ~cmd_spi_i;
  assign spi_acc   = accept & cmd_spi_i;

  // local access goes straight through, gpio writes on the accepting edge
  assign gpio_wr_o    = local_acc & cmd_write_i;
  assign gpio_addr_o  = cmd_addr_i[daq2_regs_pkg::LOC_ADDR_W-1:0];
  assign gpio_wdata_o = cmd_wdata_i;

  // ******************************
  // control state
  // ******************************

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      busy_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
      start_q     <= 1'b0;
    end else begin
      start_q     <= spi_acc;
      rsp_valid_q <= local_acc | spi.done;
      if (spi_acc) begin
        busy_q <= 1'b1;
      end else if (spi.done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // ******************************
  // request and response payload
  // ******************************

  always_ff @(posedge sys_clk) begin
    if (spi_acc) begin
      spi.dev   <= cmd_dev_i;
      spi.rd    <= ~cmd_write_i;
      spi.addr  <= cmd_addr_i;
      spi.wdata <= cmd_wdata_i[daq2_spi_pkg::SPI_DATA_W-1:0];
    end
    if (local_acc) begin
      rsp_rdata_o <= cmd_write_i ? '0 : gpio_rdata_i;
    end else if (spi.done) begin
      // spi byte is zero-extended, writes answer zero
      rsp_rdata_o <= '0;
      if (spi.rd) begin
        rsp_rdata_o[daq2_spi_pkg::SPI_DATA_W-1:0] <= spi.rdata;
      end
    end
  end

  assign spi.start   = start_q;
  assign rsp_valid_o = rsp_valid_q;
  assign busy_o      = busy_q;

endmodule

`default_nettype wire

// File: source/daq2_gpio.sv
// board gpio registers, drives the output pins, synchronizes the inputs and serves register reads
`timescale 1ns/1ns
`default_nettype none

module daq2_gpio (
  input  logic                                 sys_clk,
  input  logic                                 rst_i,
  input  logic                                 wr_i,
  input  logic [daq2_regs_pkg::LOC_ADDR_W-1:0]  addr_i,
  input  logic [daq2_regs_pkg::CMD_DATA_W-1:0]  wdata_i,
  output logic [daq2_regs_pkg::CMD_DATA_W-1:0]  rdata_o,
  output logic [daq2_regs_pkg::BD_OUT_W-1:0]    bd_out_o,
  output logic [daq2_regs_pkg::CTRL_OUT_W-1:0]  ctrl_out_o,
  input  logic [daq2_regs_pkg::BD_IN_W-1:0]     bd_in_i,
  input  logic [daq2_regs_pkg::STATUS_W-1:0]    status_i
);

  logic [daq2_regs_pkg::BD_IN_W+daq2_regs_pkg::STATUS_W-1:0] sync_q [daq2_regs_pkg::SYNC_STAGES];
  logic [daq2_regs_pkg::BD_IN_W-1:0]  bd_in_s;
  logic [daq2_regs_pkg::STATUS_W-1:0] status_s;

  // output registers
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      bd_out_o   <= '0;
      ctrl_out_o <= '0;
    end else if (wr_i) begin
      if (addr_i == daq2_regs_pkg::ADDR_BD_OUT) begin
        bd_out_o <= wdata_i[daq2_regs_pkg::BD_OUT_W-1:0];
      end
      if (addr_i == daq2_regs_pkg::ADDR_CTRL_OUT) begin
        ctrl_out_o <= wdata_i[daq2_regs_pkg::CTRL_OUT_W-1:0];
      end
    end
  end

  // board and status inputs share one synchronizer chain
  always_ff @(posedge sys_clk) begin
    sync_q[0] <= {status_i, bd_in_i};
    for (int i = 1; i < daq2_regs_pkg::SYNC_STAGES; i++) begin
      sync_q[i] <= sync_q[i-1];
    end
  end

  assign {status_s, bd_in_s} = sync_q[daq2_regs_pkg::SYNC_STAGES-1];

  // readback, zero-extended
  always_comb begin
    rdata_o = '0;
    case (addr_i)
      daq2_regs_pkg::ADDR_BD_OUT:    rdata_o[daq2_regs_pkg::BD_OUT_W-1:0]   = bd_out_o;
      daq2_regs_pkg::ADDR_CTRL_OUT:  rdata_o[daq2_regs_pkg::CTRL_OUT_W-1:0] = ctrl_out_o;
      daq2_regs_pkg::ADDR_STATUS_IN: rdata_o[daq2_regs_pkg::STATUS_W-1:0]   = status_s;
      default:                       rdata_o[daq2_regs_pkg::BD_IN_W-1:0]    = bd_in_s;
    endcase
  end

endmodule

`default_nettype wire

// File: source/daq2_spi_engine.sv
// spi master for one 24-bit frame, divides sys_clk into sclk and shifts the frame msb first
`timescale 1ns/1ns
`default_nettype none

module daq2_spi_engine (
  input  logic                           sys_clk,
  input  logic                           rst_i,
  daq2_spi_if.engine                     spi,
  output logic [daq2_spi_pkg::N_DEV-1:0] csn_o,
  output logic                           sclk_o,
  output logic                           mosi_o,
  input  logic                           miso_i
);

  logic                                 active_q;
  logic                                 done_q;
  logic [daq2_spi_pkg::DIV_CNT_W-1:0]   div_q;
  logic [daq2_spi_pkg::BIT_CNT_W-1:0]   bit_q;
  logic [daq2_spi_pkg::FRAME_W-1:0]     shift_q;
  logic [daq2_spi_pkg::SPI_DATA_W-1:0]  rx_q;
  logic                                 tick;
  logic                                 rise;
  logic                                 fall;
  logic                                 finish;

  // half period strobe and the three things it can mean
  assign tick   = active_q && (div_q == daq2_spi_pkg::DIV_LAST);
  assign rise   = tick && !sclk_o && (bit_q != daq2_spi_pkg::FRAME_CNT);
  assign fall   = tick && sclk_o;
  assign finish = tick && !sclk_o && (bit_q == daq2_spi_pkg::FRAME_CNT);

  // ******************************
  // sequencing
  // ******************************

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      csn_o    <= '1;
      sclk_o   <= 1'b0;
      div_q    <= '0;
      bit_q    <= '0;
    end else begin
      done_q <= finish;
      if (!active_q) begin
        if (spi.start) begin
          active_q       <= 1'b1;
          csn_o[spi.dev] <= 1'b0;
          div_q          <= '0;
          bit_q          <= '0;
        end
      end else begin
        div_q <= tick ? '0 : div_q + 1'b1;
        if (rise) begin
          sclk_o <= 1'b1;
          bit_q  <= bit_q + 1'b1;
        end
        if (fall) begin
          sclk_o <= 1'b0;
        end
        if (finish) begin
          active_q <= 1'b0;
          csn_o    <= '1;
        end
      end
    end
  end

  // shifter, mosi moves on the falling edge, miso sampled on the rising one
  always_ff @(posedge sys_clk) begin
    if (!active_q && spi.start) begin
      shift_q <= {spi.rd, spi.addr, spi.wdata};
    end else if (fall) begin
      shift_q <= {shift_q[daq2_spi_pkg::FRAME_W-2:0], 1'b0};
    end
    if (rise) begin
      rx_q <= {rx_q[daq2_spi_pkg::SPI_DATA_W-2:0], miso_i};
    end
  end

  assign mosi_o    = shift_q[daq2_spi_pkg::FRAME_W-1];
  assign spi.rdata = rx_q;
  assign spi.done  = done_q;

endmodule

`default_nettype wire

// File: source/daq2_spi_sdio.sv
// 3-wire sdio glue, follows each frame on the bus and hands the line to the device for read data
`timescale 1ns/1ns
`default_nettype none

module daq2_spi_sdio (
  input  logic                           sys_clk,
  input  logic                           rst_i,
  input  logic [daq2_spi_pkg::N_DEV-1:0] csn_i,
  input  logic                           sclk_i,
  input  logic                           mosi_i,
  output logic                           miso_o,
  output logic                           sdio_o,
  input  logic                           sdio_i,
  output logic                           dir_o
);

  logic                               sclk_d;
  logic                               rd_q;
  logic                               dir_q;
  logic [daq2_spi_pkg::BIT_CNT_W-1:0] cnt_q;
  logic                               idle;
  logic                               sclk_rise;

  // bus is idle when no chip select is low
  assign idle      = &csn_i;
  assign sclk_rise = sclk_i & ~sclk_d;

  // ******************************
  // frame tracking
  // ******************************

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      sclk_d <= 1'b0;
      rd_q   <= 1'b0;
      dir_q  <= 1'b1;
      cnt_q  <= '0;
    end else begin
      sclk_d <= sclk_i;
      if (idle) begin
        cnt_q <= '0;
        dir_q <= 1'b1;
      end else if (sclk_rise) begin
        cnt_q <= cnt_q + 1'b1;
        // first bit of the instruction is the read flag
        if (cnt_q == '0) begin
          rd_q <= mosi_i;
        end
        // release the line once the instruction is out
        if (cnt_q == daq2_spi_pkg::INSTR_LAST && rd_q) begin
          dir_q <= 1'b0;
        end
      end
    end
  end

  // fpga drives again as soon as the frame ends
  assign dir_o  = dir_q | idle;
  assign sdio_o = mosi_i;
  assign miso_o = sdio_i;

endmodule

`default_nettype wire

// File: source/daq2_top.sv
// board-control top level, wires the host port, gpio pins and the shared spi bus to the blocks
`timescale 1ns/1ns
`default_nettype none

module daq2_top (
  input  logic                                 sys_clk,
  input  logic                                 rst_i,

  // host port
  input  logic                                 cmd_valid_i,
  input  logic                                 cmd_spi_i,
  input  logic                                 cmd_write_i,
  input  logic [daq2_spi_pkg::DEV_W-1:0]        cmd_dev_i,
  input  logic [daq2_spi_pkg::SPI_ADDR_W-1:0]   cmd_addr_i,
  input  logic [daq2_regs_pkg::CMD_DATA_W-1:0]  cmd_wdata_i,
  output logic                                 rsp_valid_o,
  output logic [daq2_regs_pkg::CMD_DATA_W-1:0]  rsp_rdata_o,
  output logic                                 busy_o,

  // spi
  output logic                                 spi_csn_clk_o,
  output logic                                 spi_csn_dac_o,
  output logic                                 spi_csn_adc_o,
  output logic                                 spi_clk_o,
  output logic                                 spi_sdio_o,
  input  logic                                 spi_sdio_i,
  output logic                                 spi_dir_o,

  // board gpio
  input  logic [daq2_regs_pkg::BD_IN_W-1:0]     gpio_bd_i,
  output logic [daq2_regs_pkg::BD_OUT_W-1:0]    gpio_bd_o,

  // converter gpio
  input  logic                                 trig_i,
  input  logic                                 adc_fda_i,
  input  logic                                 adc_fdb_i,
  input  logic                                 dac_irq_i,
  input  logic [daq2_regs_pkg::STAT_CLKD_W-1:0] clkd_status_i,
  output logic                                 adc_pd_o,
  output logic                                 dac_txen_o,
  output logic                                 dac_reset_o,
  output logic                                 clkd_sync_o
);

  logic                                 gpio_wr;
  logic [daq2_regs_pkg::LOC_ADDR_W-1:0] gpio_addr;
  logic [daq2_regs_pkg::CMD_DATA_W-1:0] gpio_wdata;
  logic [daq2_regs_pkg::CMD_DATA_W-1:0] gpio_rdata;
  logic [daq2_regs_pkg::CTRL_OUT_W-1:0] ctrl_out;
  logic [daq2_regs_pkg::STATUS_W-1:0]   status;
  logic [daq2_spi_pkg::N_DEV-1:0]       spi_csn;
  logic                                 spi_mosi;
  logic                                 spi_miso;

  daq2_spi_if spi_if ();

  // ******************************
  // pin mapping
  // ******************************

  assign status[daq2_regs_pkg::STAT_CLKD +: daq2_regs_pkg::STAT_CLKD_W] = clkd_status_i;
  assign status[daq2_regs_pkg::STAT_DAC_IRQ] = dac_irq_i;
  assign status[daq2_regs_pkg::STAT_ADC_FDA] = adc_fda_i;
  assign status[daq2_regs_pkg::STAT_ADC_FDB] = adc_fdb_i;
  assign status[daq2_regs_pkg::STAT_TRIG]    = trig_i;

  assign dac_reset_o = ctrl_out[daq2_regs_pkg::CTRL_DAC_RESET];
  assign dac_txen_o  = ctrl_out[daq2_regs_pkg::CTRL_DAC_TXEN];
  assign adc_pd_o    = ctrl_out[daq2_regs_pkg::CTRL_ADC_PD];
  assign clkd_sync_o = ctrl_out[daq2_regs_pkg::CTRL_CLKD_SYNC];

  assign spi_csn_clk_o = spi_csn[daq2_spi_pkg::DEV_CLK];
  assign spi_csn_dac_o = spi_csn[daq2_spi_pkg::DEV_DAC];
  assign spi_csn_adc_o = spi_csn[daq2_spi_pkg::DEV_ADC];

  // ******************************
  // blocks
  // ******************************

  daq2_ctrl i_ctrl (
    .sys_clk      (sys_clk),
    .rst_i        (rst_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_spi_i    (cmd_spi_i),
    .cmd_write_i  (cmd_write_i),
    .cmd_dev_i    (cmd_dev_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_wdata_i  (cmd_wdata_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_rdata_o  (rsp_rdata_o),
    .busy_o       (busy_o),
    .gpio_wr_o    (gpio_wr),
    .gpio_addr_o  (gpio_addr),
    .gpio_wdata_o (gpio_wdata),
    .gpio_rdata_i (gpio_rdata),
    .spi          (spi_if.ctrl));

  daq2_gpio i_gpio (
    .sys_clk    (sys_clk),
    .rst_i      (rst_i),
    .wr_i       (gpio_wr),
    .addr_i     (gpio_addr),
    .wdata_i    (gpio_wdata),
    .rdata_o    (gpio_rdata),
    .bd_out_o   (gpio_bd_o),
    .ctrl_out_o (ctrl_out),
    .bd_in_i    (gpio_bd_i),
    .status_i   (status));

  daq2_spi_engine i_spi_engine (
    .sys_clk (sys_clk),
    .rst_i   (rst_i),
    .spi     (spi_if.engine),
    .csn_o   (spi_csn),
    .sclk_o  (spi_clk_o),
    .mosi_o  (spi_mosi),
    .miso_i  (spi_miso));

  daq2_spi_sdio i_spi_sdio (
    .sys_clk (sys_clk),
    .rst_i   (rst_i),
    .csn_i   (spi_csn),
    .sclk_i  (spi_clk_o),
    .mosi_i  (spi_mosi),
    .miso_o  (spi_miso),
    .sdio_o  (spi_sdio_o),
    .sdio_i  (spi_sdio_i),
    .dir_o   (spi_dir_o));

endmodule

`default_nettype wire

// File: verif/daq2_properties.sv
// bus-level assertions for the board-control top level, attached to every daq2_top by bind
`timescale 1ns/1ns
`default_nettype none

module daq2_properties (
  input logic sys_clk,
  input logic rst_i,
  input logic csn_clk_i,
  input logic csn_dac_i,
  input logic csn_adc_i,
  input logic dir_i,
  input logic rsp_valid_i
);

  logic [2:0] csn;

  assign csn = {csn_adc_i, csn_dac_i, csn_clk_i};

  // shared bus, one device at a time
  one_csn_low: assert property (@(posedge sys_clk) disable iff (rst_i)
    $countones(~csn) <= 1)
    else $error("more than one chip select low");

  // fpga owns sdio whenever the bus is idle
  dir_when_idle: assert property (@(posedge sys_clk) disable iff (rst_i)
    (&csn) |-> dir_i)
    else $error("sdio released while no chip select is low");

  rsp_single: assert property (@(posedge sys_clk) disable iff (rst_i)
    rsp_valid_i |=> !rsp_valid_i)
    else $error("response valid high for two cycles");

endmodule

bind daq2_top daq2_properties u_properties (
  .sys_clk     (sys_clk),
  .rst_i       (rst_i),
  .csn_clk_i   (spi_csn_clk_o),
  .csn_dac_i   (spi_csn_dac_o),
  .csn_adc_i   (spi_csn_adc_o),
  .dir_i       (spi_dir_o),
  .rsp_valid_i (rsp_valid_o));

`default_nettype wire

// File: verif/daq2_tb.sv
// board-control testbench that runs random host commands against a reference model
`timescale 1ns/1ns
`default_nettype none

module daq2_tb;

  localparam int MAX_CYCLES = 20000;
  localparam int N_ROUNDS   = 10;
  localparam int N_SPI      = 40;

  logic        sys_clk       = 1'b0;
  logic        rst_i         = 1'b1;
  logic        cmd_valid_i   = 1'b0;
  logic        cmd_spi_i     = 1'b0;
  logic        cmd_write_i   = 1'b0;
  logic [1:0]  cmd_dev_i     = '0;
  logic [14:0] cmd_addr_i    = '0;
  logic [15:0] cmd_wdata_i   = '0;
  logic        spi_sdio_i    = 1'b0;
  logic [10:0] gpio_bd_i     = '0;
  logic        trig_i        = 1'b0;
  logic        adc_fda_i     = 1'b0;
  logic        adc_fdb_i     = 1'b0;
  logic        dac_irq_i     = 1'b0;
  logic [1:0]  clkd_status_i = '0;
  logic        rsp_valid_o;
  logic [15:0] rsp_rdata_o;
  logic        busy_o;
  logic        spi_csn_clk_o;
  logic        spi_csn_dac_o;
  logic        spi_csn_adc_o;
  logic        spi_clk_o;
  logic        spi_sdio_o;
  logic        spi_dir_o;
  logic [15:0] gpio_bd_o;
  logic        adc_pd_o;
  logic        dac_txen_o;
  logic        dac_reset_o;
  logic        clkd_sync_o;

  // reference model
  logic [15:0] bd_out_m;
  logic [3:0]  ctrl_out_m;
  logic [7:0]  mem_m [3][256];
  int          exp_dev;

  // spi device model and bus monitors
  logic [7:0]  dev_mem [3][256];
  logic [15:0] dev_instr;
  logic [7:0]  dev_data;
  logic [7:0]  dev_rout;
  logic        sclk_seen;
  logic [2:0]  csn_vec;
  logic [2:0]  csn_exp;
  int          sel_dev;
  int          dev_bits;
  int          rsp_count   = 0;
  int          dir_low_cnt = 0;
  int          cycles      = 0;

  always #20 sys_clk = ~sys_clk;

  daq2_top UUT (.*);

  // chip selects indexed by device code
  assign csn_vec = {spi_csn_adc_o, spi_csn_dac_o, spi_csn_clk_o};
  assign csn_exp = ~(3'b001 << exp_dev);

  always_comb begin
    sel_dev = 0;
    for (int d = 0; d < daq2_spi_pkg::N_DEV; d++) begin
      if (!csn_vec[d]) begin
        sel_dev = d;
      end
    end
  end

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // ******************************
  // spi device and monitors
  // ******************************

  always @(posedge sys_clk) begin
    sclk_seen <= spi_clk_o;
    if (rst_i) begin
      for (int d = 0; d < daq2_spi_pkg::N_DEV; d++) begin
        for (int a = 0; a < 256; a++) begin
          dev_mem[d][a] <= 8'h00;
        end
      end
      dev_bits <= 0;
    end else if (&csn_vec) begin
      dev_bits <= 0;
    end else begin
      check_equal(32'(csn_vec), 32'(csn_exp), "only the addressed chip select is low");
      // fpga keeps sdio until the whole instruction is out
      if (!spi_dir_o) begin
        check_equal(32'(dev_bits >= daq2_spi_pkg::INSTR_W), 32'(1),
                    "sdio released only after the instruction");
      end
      // sdio is stable at the sclk rising edge
      if (spi_clk_o && !sclk_seen) begin
        dev_bits <= dev_bits + 1;
        if (dev_bits < daq2_spi_pkg::INSTR_W) begin
          dev_instr <= {dev_instr[daq2_spi_pkg::INSTR_W-2:0], spi_sdio_o};
        end else begin
          dev_data <= {dev_data[6:0], spi_sdio_o};
          dev_rout <= {dev_rout[6:0], 1'b0};
        end
        if (dev_bits == daq2_spi_pkg::INSTR_W - 1) begin
          dev_rout <= dev_mem[sel_dev][{dev_instr[6:0], spi_sdio_o}];
        end
        if (dev_bits == daq2_spi_pkg::FRAME_W - 1 && !dev_instr[daq2_spi_pkg::INSTR_W-1]) begin
          dev_mem[sel_dev][dev_instr[7:0]] <= {dev_data[6:0], spi_sdio_o};
        end
      end
    end
  end

  // device only drives the line once the fpga has released it
  always @(posedge sys_clk) begin
    spi_sdio_i <= spi_dir_o ? 1'b0 : dev_rout[7];
  end

  always @(posedge sys_clk) begin
    if (rsp_valid_o) begin
      rsp_count <= rsp_count + 1;
    end
    if (!spi_dir_o) begin
      dir_low_cnt <= dir_low_cnt + 1;
    end
  end

  always @(posedge sys_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  // ******************************
  // host commands
  // ******************************

  task automatic issue(input logic spi, input logic wr, input int dev,
                       input logic [14:0] addr, input logic [15:0] wdata);
    @(posedge sys_clk);
    cmd_valid_i <= 1'b1;
    cmd_spi_i   <= spi;
    cmd_write_i <= wr;
    cmd_dev_i   <= 2'(dev);
    cmd_addr_i  <= addr;
    cmd_wdata_i <= wdata;
    @(posedge sys_clk);
    cmd_valid_i <= 1'b0;
  endtask

  task automatic check_pins();
    check_equal(32'(gpio_bd_o), 32'(bd_out_m), "board outputs");
    check_equal(32'(dac_reset_o), 32'(ctrl_out_m[daq2_regs_pkg::CTRL_DAC_RESET]), "dac reset");
    check_equal(32'(dac_txen_o), 32'(ctrl_out_m[daq2_regs_pkg::CTRL_DAC_TXEN]), "dac txen");
    check_equal(32'(adc_pd_o), 32'(ctrl_out_m[daq2_regs_pkg::CTRL_ADC_PD]), "adc power down");
    check_equal(32'(clkd_sync_o), 32'(ctrl_out_m[daq2_regs_pkg::CTRL_CLKD_SYNC]), "clock sync");
  endtask

  // local response comes exactly one cycle after acceptance
  task automatic local_access(input logic wr, input logic [1:0] addr,
                              input logic [15:0] wdata, input logic [15:0] exp);
    issue(1'b0, wr, 0, {13'($urandom), addr}, wdata);
    @(posedge sys_clk);
    check_equal(32'(rsp_valid_o), 32'(1), "local response one cycle after command");
    check_equal(32'(rsp_rdata_o), 32'(exp), "local response data");
    check_equal(32'(busy_o), 32'(0), "busy stays low on local command");
    check_pins();
    @(posedge sys_clk);
    check_equal(32'(rsp_valid_o), 32'(0), "single local response");
  endtask

  task automatic input_readback();
    logic [1:0]  clkd;
    logic [3:0]  flags;
    logic [10:0] bd;
    logic [15:0] exp;
    clkd  = 2'($urandom);
    flags = 4'($urandom);
    bd    = 11'($urandom);
    @(posedge sys_clk);
    clkd_status_i <= clkd;
    dac_irq_i     <= flags[0];
    adc_fda_i     <= flags[1];
    adc_fdb_i     <= flags[2];
    trig_i        <= flags[3];
    gpio_bd_i     <= bd;
    repeat (3) @(posedge sys_clk);
    exp = '0;
    exp[daq2_regs_pkg::STAT_CLKD +: daq2_regs_pkg::STAT_CLKD_W] = clkd;
    exp[daq2_regs_pkg::STAT_DAC_IRQ] = flags[0];
    exp[daq2_regs_pkg::STAT_ADC_FDA] = flags[1];
    exp[daq2_regs_pkg::STAT_ADC_FDB] = flags[2];
    exp[daq2_regs_pkg::STAT_TRIG]    = flags[3];
    local_access(1'b0, daq2_regs_pkg::ADDR_STATUS_IN, 16'($urandom), exp);
    local_access(1'b0, daq2_regs_pkg::ADDR_BD_IN, 16'($urandom), {5'b0, bd});
  endtask

  // one spi frame with an optional stray command while busy
  task automatic spi_access(input logic wr, input int dev, input logic [14:0] addr,
                            input logic [7:0] wdata, input logic poke);
    int          waited;
    int          dir_before;
    int          rsp_before;
    logic [15:0] exp;
    exp        = wr ? 16'h0000 : {8'h00, mem_m[dev][addr[7:0]]};
    exp_dev    = dev;
    dir_before = dir_low_cnt;
    rsp_before = rsp_count;
    issue(1'b1, wr, dev, addr, {8'($urandom), wdata});
    @(posedge sys_clk);
    check_equal(32'(busy_o), 32'(1), "busy the cycle after spi command");
    waited = 0;
    while (!rsp_valid_o) begin
      if (poke && waited == 10) begin
        cmd_valid_i <= 1'b1;
        cmd_spi_i   <= 1'b0;
        cmd_write_i <= 1'b1;
        cmd_addr_i  <= 15'(daq2_regs_pkg::ADDR_BD_OUT);
        cmd_wdata_i <= ~bd_out_m;
      end else begin
        cmd_valid_i <= 1'b0;
      end
      @(posedge sys_clk);
      waited++;
    end
    check_equal(32'(rsp_rdata_o), 32'(exp), "spi response data");
    check_equal(32'(busy_o), 32'(0), "busy falls with spi response");
    check_equal(32'(spi_dir_o), 32'(1), "fpga drives sdio after the frame");
    check_equal(32'(dir_low_cnt != dir_before), 32'(!wr), "sdio turnaround only on reads");
    if (wr) begin
      mem_m[dev][addr[7:0]] = wdata;
    end
    @(posedge sys_clk);
    check_equal(32'(rsp_count), 32'(rsp_before + 1), "one response per spi command");
    check_pins();
  endtask

  // ******************************
  // test sequence
  // ******************************

  initial begin
    logic [15:0] wval;
    logic [14:0] addr;
    int          dev;
    void'($urandom(32'h3f62_cb3d));
    bd_out_m   = '0;
    ctrl_out_m = '0;
    exp_dev    = 0;
    for (int d = 0; d < daq2_spi_pkg::N_DEV; d++) begin
      for (int a = 0; a < 256; a++) begin
        mem_m[d][a] = 8'h00;
      end
    end
    repeat (5) @(posedge sys_clk);
    rst_i <= 1'b0;
    @(posedge sys_clk);
    check_pins();
    check_equal(32'(csn_vec), 32'h7, "chip selects high after reset");
    check_equal(32'(spi_clk_o), 32'(0), "sclk low after reset");
    check_equal(32'(spi_dir_o), 32'(1), "fpga drives sdio after reset");
    check_equal(32'(busy_o), 32'(0), "busy low after reset");
    check_equal(32'(rsp_valid_o), 32'(0), "no response after reset");

    for (int i = 0; i < N_ROUNDS; i++) begin
      wval     = 16'($urandom);
      bd_out_m = wval;
      local_access(1'b1, daq2_regs_pkg::ADDR_BD_OUT, wval, 16'h0000);
      wval       = 16'($urandom);
      ctrl_out_m = wval[daq2_regs_pkg::CTRL_OUT_W-1:0];
      local_access(1'b1, daq2_regs_pkg::ADDR_CTRL_OUT, wval, 16'h0000);
      local_access(1'b0, daq2_regs_pkg::ADDR_BD_OUT, 16'($urandom), bd_out_m);
      local_access(1'b0, daq2_regs_pkg::ADDR_CTRL_OUT, 16'($urandom), {12'h000, ctrl_out_m});
      input_readback();
    end

    // writes first and then reads over the same small address window
    for (int i = 0; i < N_SPI; i++) begin
      dev  = $urandom_range(0, daq2_spi_pkg::N_DEV - 1);
      addr = {7'($urandom), 8'($urandom_range(0, 15))};
      spi_access(i < N_SPI / 2, dev, addr, 8'($urandom), (i % 4) == 1);
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
source/daq2_regs_pkg.sv
source/daq2_spi_pkg.sv
source/daq2_spi_if.sv
source/daq2_ctrl.sv
source/daq2_gpio.sv
source/daq2_spi_engine.sv
source/daq2_spi_sdio.sv
source/daq2_top.sv
verif/daq2_properties.sv
verif/daq2_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the board-control testbench with Verilator and runs it
# the exit status of the simulation is the test result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module daq2_tb \
  -Mdir obj_dir \
  -o daq2_sim

./obj_dir/daq2_sim
